/* design/invaders_consts.svh */
`ifndef INVADERS_CONSTS_SVH
`define INVADERS_CONSTS_SVH

// Anything at or beyond the visible area of the raster is blanked
`define INV_SCREEN_W 640
`define INV_SCREEN_H 480

// Every raster and object coordinate is carried in this many bits
`define INV_COORD_W 11

// Pixel colours, 8 bits per pixel
`define INV_COLOR_BG      8'h48
`define INV_COLOR_FG      8'hDD
`define INV_COLOR_WOUNDED 8'h3C
`define INV_COLOR_NULL    8'h00

// One invader cell is CELL pixels wide and the ship block uses the same size
`define INV_CELL 32

// Row boxes are inclusive on both ends, so a row spans LEN+1 pixels
`define INV_ROW_LEN 350
`define INV_ROW_H   30
`define INV_COLS    11
`define INV_ROWS    3
`define INV_GRID_X  128
`define INV_ROW0_Y  64
`define INV_ROW1_Y  96
`define INV_ROW2_Y  128

// Player ship, which only moves horizontally
`define INV_PLAYER_X0   320
`define INV_PLAYER_Y    416
`define INV_PLAYER_XMAX 608

// Bullet spawn offsets relative to the ship, and climb per frame (also its size)
`define INV_BULLET_DX   14
`define INV_BULLET_DY   8
`define INV_BULLET_STEP 4

`endif

/* design/invaders_pkg.sv */
`include "invaders_consts.svh"

package invaders_pkg;

	// Screen coordinate, wide enough for the raster counters
	typedef logic [`INV_COORD_W-1:0] coord_t;

	// One pixel colour
	typedef logic [7:0] color_t;

	// One bit per invader in a row
	// Bit 0 is the leftmost column
	typedef logic [`INV_COLS-1:0] row_mask_t;

	// A single bullet can be on screen at a time
	typedef enum logic
	{
		BULLET_IDLE,
		BULLET_FLYING
	} bullet_state_t;

endpackage

/* design/player_ctrl.sv */
`timescale 1ns/1ps
`include "invaders_consts.svh"

module player_ctrl (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 frame_tick,
	input  logic                 btn_left,
	input  logic                 btn_right,
	output invaders_pkg::coord_t player_x
);

	import invaders_pkg::*;

	coord_t x_next;

	// Next position, evaluated every cycle but only taken on a frame tick
	// Both tests are independent, so with both buttons held the right move
	// overrides the left one
	always_comb
	begin
		x_next = player_x;
		if (btn_left && player_x > coord_t'(1))
		begin
			x_next = player_x - coord_t'(1);
		end
		if (btn_right && player_x < coord_t'(`INV_PLAYER_XMAX))
		begin
			x_next = player_x + coord_t'(1);
		end
	end

	// The ship moves at most one pixel per frame
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			player_x <= coord_t'(`INV_PLAYER_X0);
		end
		else if (frame_tick)
		begin
			player_x <= x_next;
		end
	end

endmodule

/* design/bullet_ctrl.sv */
`timescale 1ns/1ps
`include "invaders_consts.svh"

module bullet_ctrl (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 frame_tick,
	input  logic                 btn_fire,
	input  logic                 hit,
	input  invaders_pkg::coord_t player_x,
	output invaders_pkg::coord_t bullet_x,
	output invaders_pkg::coord_t bullet_y,
	output logic                 bullet_active
);

	import invaders_pkg::*;

	bullet_state_t state;

	// Spawn point sits above the middle of the ship
	coord_t spawn_x;

	assign spawn_x = coord_t'(player_x + `INV_BULLET_DX);

	// Only a flying bullet is drawn or can hit anything
	assign bullet_active = (state == BULLET_FLYING);

	// A hit comes from the invader grid and always wins over the frame update
	// The frame update either launches a new bullet or moves the current one
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= BULLET_IDLE;
			bullet_x <= '0;
			bullet_y <= '0;
		end
		else if (hit)
		begin
			state <= BULLET_IDLE;
		end
		else if (frame_tick)
		begin
			case (state)
				BULLET_IDLE:
				begin
					// Fire is sampled once per frame
					if (btn_fire)
					begin
						state    <= BULLET_FLYING;
						bullet_x <= spawn_x;
						bullet_y <= coord_t'(`INV_PLAYER_Y - `INV_BULLET_DY);
					end
				end
				BULLET_FLYING:
				begin
					// The bullet spends one frame on the top line before it expires
					if (bullet_y == '0)
					begin
						state <= BULLET_IDLE;
					end
					else if (bullet_y < coord_t'(`INV_BULLET_STEP))
					begin
						bullet_y <= '0;
					end
					else
					begin
						bullet_y <= bullet_y - coord_t'(`INV_BULLET_STEP);
					end
				end
				default:
				begin
					state <= BULLET_IDLE;
				end
			endcase
		end
	end

endmodule

/* design/invader_grid.sv */
`timescale 1ns/1ps
`include "invaders_consts.svh"

module invader_grid (
	input  logic                 clk,
	input  logic                 arst_n,
	input  invaders_pkg::coord_t x,
	input  invaders_pkg::coord_t y,
	input  invaders_pkg::coord_t bullet_x,
	input  invaders_pkg::coord_t bullet_y,
	input  logic                 bullet_active,
	output logic                 hit,
	output logic                 inv_here,
	output invaders_pkg::color_t inv_color
);

	import invaders_pkg::*;

	localparam coord_t GRID_X  = coord_t'(`INV_GRID_X);
	localparam coord_t ROW_LEN = coord_t'(`INV_ROW_LEN);
	localparam coord_t ROW_H   = coord_t'(`INV_ROW_H);
	localparam coord_t ROW_TOP [`INV_ROWS] = '{
		coord_t'(`INV_ROW0_Y),
		coord_t'(`INV_ROW1_Y),
		coord_t'(`INV_ROW2_Y)
	};

	// A set bit in alive means the invader is still on screen
	// A cleared bit in healthy means it has already taken one hit
	row_mask_t alive   [`INV_ROWS];
	row_mask_t healthy [`INV_ROWS];

	// Row and column under the bullet and under the current pixel
	logic [1:0] b_row;
	logic [1:0] p_row;
	logic [3:0] b_col;
	logic [3:0] p_col;
	logic       b_in_row;
	logic       p_in_row;

	// Returns the row box holding the point, and the lowest row number wins
	// The value INV_ROWS means that no row holds it
	function automatic logic [1:0] row_select(input coord_t px, input coord_t py);
		logic [1:0] sel;
		sel = 2'(`INV_ROWS);
		if (px >= GRID_X && px <= GRID_X + ROW_LEN)
		begin
			// Walk downwards so that the lowest matching row is written last
			for (int r = `INV_ROWS - 1; r >= 0; r--)
			begin
				if (py >= ROW_TOP[r] && py <= ROW_TOP[r] + ROW_H)
				begin
					sel = 2'(r);
				end
			end
		end
		return sel;
	endfunction

	// The column index inside a row only means something when the point is in a row box
	function automatic logic [3:0] col_select(input coord_t px);
		coord_t offset;
		offset = px - GRID_X;
		return 4'(offset / coord_t'(`INV_CELL));
	endfunction

	assign b_row    = row_select(bullet_x, bullet_y);
	assign p_row    = row_select(x, y);
	assign b_col    = col_select(bullet_x);
	assign p_col    = col_select(x);
	assign b_in_row = (b_row != 2'(`INV_ROWS));
	assign p_in_row = (p_row != 2'(`INV_ROWS));

	// A hit is seen only on the one raster pixel that sits on the bullet,
	// which makes it a single-cycle pulse per frame
	assign hit = bullet_active && (x == bullet_x) && (y == bullet_y)
		&& b_in_row && alive[b_row][b_col];

	// Invader under the current pixel, drawn as a solid block
	assign inv_here  = p_in_row && alive[p_row][p_col];
	assign inv_color = (p_in_row && !healthy[p_row][p_col]) ?
		`INV_COLOR_WOUNDED : `INV_COLOR_FG;

	// First hit wounds, second hit removes
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int r = 0; r < `INV_ROWS; r++)
			begin
				alive[r]   <= '1;
				healthy[r] <= '1;
			end
		end
		else if (hit)
		begin
			if (healthy[b_row][b_col])
			begin
				healthy[b_row][b_col] <= 1'b0;
			end
			else
			begin
				alive[b_row][b_col] <= 1'b0;
			end
		end
	end

endmodule

/* design/pixel_painter.sv */
`timescale 1ns/1ps
`include "invaders_consts.svh"

module pixel_painter (
	input  logic                 clk,
	input  logic                 arst_n,
	input  invaders_pkg::coord_t x,
	input  invaders_pkg::coord_t y,
	input  invaders_pkg::coord_t player_x,
	input  invaders_pkg::coord_t bullet_x,
	input  invaders_pkg::coord_t bullet_y,
	input  logic                 bullet_active,
	input  logic                 inv_here,
	input  invaders_pkg::color_t inv_color,
	output invaders_pkg::color_t rgb
);

	import invaders_pkg::*;

	logic   on_screen;
	logic   on_ship;
	logic   on_bullet;
	color_t color_next;

	assign on_screen = (x < coord_t'(`INV_SCREEN_W)) && (y < coord_t'(`INV_SCREEN_H));

	// The ship block is inclusive on both ends
	assign on_ship = (x >= player_x) && (x <= player_x + coord_t'(`INV_CELL))
		&& (y >= coord_t'(`INV_PLAYER_Y))
		&& (y <= coord_t'(`INV_PLAYER_Y + `INV_CELL));

	// The bullet block is a small square anchored at its top-left corner
	assign on_bullet = bullet_active
		&& (x >= bullet_x) && (x <= bullet_x + coord_t'(`INV_BULLET_STEP))
		&& (y >= bullet_y) && (y <= bullet_y + coord_t'(`INV_BULLET_STEP));

	// Later layers overwrite earlier ones, so the bullet is always on top
	always_comb
	begin
		if (!on_screen)
		begin
			color_next = `INV_COLOR_NULL;
		end
		else
		begin
			color_next = `INV_COLOR_BG;
			if (inv_here)
			begin
				color_next = inv_color;
			end
			if (on_ship)
			begin
				color_next = `INV_COLOR_FG;
			end
			if (on_bullet)
			begin
				color_next = `INV_COLOR_FG;
			end
		end
	end

	// Output register, one pixel of latency
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rgb <= `INV_COLOR_NULL;
		end
		else
		begin
			rgb <= color_next;
		end
	end

endmodule

/* design/invaders_top.sv */
`timescale 1ns/1ps

module invaders_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  invaders_pkg::coord_t x,
	input  invaders_pkg::coord_t y,
	input  logic                 btn_left,
	input  logic                 btn_right,
	input  logic                 btn_fire,
	output invaders_pkg::color_t rgb
);

	import invaders_pkg::*;

	logic   frame_tick;
	logic   hit;
	logic   bullet_active;
	logic   inv_here;
	coord_t player_x;
	coord_t bullet_x;
	coord_t bullet_y;
	color_t inv_color;

	// The raster origin marks the start of a frame
	// It lasts one cycle because the raster moves on every clock
	assign frame_tick = (x == '0) && (y == '0);

	player_ctrl u_player (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.player_x   (player_x)
	);

	// The bullet reacts to hits, the grid decides them
	bullet_ctrl u_bullet (
		.clk           (clk),
		.arst_n        (arst_n),
		.frame_tick    (frame_tick),
		.btn_fire      (btn_fire),
		.hit           (hit),
		.player_x      (player_x),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active)
	);

	invader_grid u_grid (
		.clk           (clk),
		.arst_n        (arst_n),
		.x             (x),
		.y             (y),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active),
		.hit           (hit),
		.inv_here      (inv_here),
		.inv_color     (inv_color)
	);

	pixel_painter u_painter (
		.clk           (clk),
		.arst_n        (arst_n),
		.x             (x),
		.y             (y),
		.player_x      (player_x),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active),
		.inv_here      (inv_here),
		.inv_color     (inv_color),
		.rgb           (rgb)
	);

endmodule

/* testbench/invaders_checker.sv */
`timescale 1ns/1ps

module invaders_checker (
	input  logic                 clk,
	input  logic                 strobe,
	input  string                test_name,
	input  invaders_pkg::coord_t probe_x,
	input  invaders_pkg::coord_t probe_y,
	input  invaders_pkg::color_t expected,
	input  invaders_pkg::color_t rgb,
	input  logic                 done,
	input  int                   assert_fails,
	output int                   check_count,
	output int                   error_count
);

	import invaders_pkg::*;

	// A probe seen on one edge is judged on the next one,
	// since rgb trails the raster by one register
	logic   pending = 1'b0;
	string  name_q;
	coord_t x_q;
	coord_t y_q;
	color_t exp_q;
	int     checks = 0;
	int     errors = 0;

	assign check_count = checks;
	assign error_count = errors;

	always @(posedge clk)
	begin
		if (pending)
		begin
			checks++;
			// A wrong value and an unknown one both count as a mismatch
			if (rgb !== exp_q)
			begin
				errors++;
				$display("FAILED %s at (%0d, %0d): rgb = 0x%02h, expected 0x%02h",
					name_q, x_q, y_q, rgb, exp_q);
			end
			else
			begin
				$display("ok     %s at (%0d, %0d): rgb = 0x%02h", name_q, x_q, y_q, rgb);
			end
		end
		pending <= strobe;
		name_q  <= test_name;
		x_q     <= probe_x;
		y_q     <= probe_y;
		exp_q   <= expected;
	end

	// The closing summary also counts the assertion failures
	always @(posedge done)
	begin
		$display("%0d checks, %0d mismatches, %0d assertion failures",
			checks, errors, assert_fails);
	end

endmodule

/* testbench/invaders_sva.sv */
`timescale 1ns/1ps
`include "invaders_consts.svh"

module invaders_sva (
	input logic                          clk,
	input logic                          arst_n,
	input logic                          hit,
	input logic                          bullet_active,
	input invaders_pkg::bullet_state_t   state,
	input invaders_pkg::row_mask_t       alive0,
	input invaders_pkg::row_mask_t       alive1,
	input invaders_pkg::row_mask_t       alive2,
	input invaders_pkg::row_mask_t       healthy0,
	input invaders_pkg::row_mask_t       healthy1,
	input invaders_pkg::row_mask_t       healthy2
);

	import invaders_pkg::*;

	// Read by the testbench at the end of the run
	int fail_count = 0;

	logic [6*`INV_COLS-1:0] masks;

	assign masks = {alive0, alive1, alive2, healthy0, healthy1, healthy2};

	// The bullet FSM drops the bullet after its hit, so the pulse never repeats
	hit_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		hit |=> !hit)
	else
	begin
		$error("hit pulse lasted longer than one cycle");
		fail_count++;
	end

	// The bullet is spent by the hit
	idle_after_hit: assert property (@(posedge clk) disable iff (!arst_n)
		hit |=> (state == BULLET_IDLE))
	else
	begin
		$error("bullet still flying on the cycle after a hit");
		fail_count++;
	end

	// Wounds and kills are permanent until the next reset
	masks_only_fall: assert property (@(posedge clk) disable iff (!arst_n)
		(masks & ~$past(masks)) == '0)
	else
	begin
		$error("an invader mask bit came back to 1 without a reset");
		fail_count++;
	end

endmodule

// Watches the bullet FSM and the grid masks inside the top level
bind invaders_top invaders_sva u_sva (
	.clk           (clk),
	.arst_n        (arst_n),
	.hit           (u_grid.hit),
	.bullet_active (u_bullet.bullet_active),
	.state         (u_bullet.state),
	.alive0        (u_grid.alive[0]),
	.alive1        (u_grid.alive[1]),
	.alive2        (u_grid.alive[2]),
	.healthy0      (u_grid.healthy[0]),
	.healthy1      (u_grid.healthy[1]),
	.healthy2      (u_grid.healthy[2])
);

/* testbench/invaders_tb.sv */
`timescale 1ns/1ps
`include "invaders_consts.svh"

module invaders_tb;

	import invaders_pkg::*;

	// Where the probe of a table entry lands
	localparam int AT_FIXED  = 0;
	localparam int AT_BULLET = 1;
	localparam int AT_TARGET = 2;

	// Buttons are held for a number of frames, then one pixel is probed
	// A negative frame count walks the ship under the target column instead
	// For AT_TARGET, px is a column offset from the target (1 means a neighbour)
	typedef struct {
		string  name;
		logic   left;
		logic   right;
		logic   fire;
		int     frames;
		int     mode;
		int     px;
		int     py;
		color_t color;
	} test_t;

	logic   clk;
	logic   arst_n;
	coord_t x;
	coord_t y;
	logic   btn_left;
	logic   btn_right;
	logic   btn_fire;
	color_t rgb;

	// Probe side of the checker
	logic   strobe;
	logic   done;
	string  test_name;
	color_t expected;
	int     check_count;
	int     error_count;

	test_t tests[$];

	// The layout rules predict this game state, and it steers the raster
	int ship_x;
	bit m_active;
	int m_bx;
	int m_by;
	bit m_alive   [`INV_ROWS][`INV_COLS];
	bit m_healthy [`INV_ROWS][`INV_COLS];
	int row_top   [`INV_ROWS] = '{`INV_ROW0_Y, `INV_ROW1_Y, `INV_ROW2_Y};
	int target_col;

	invaders_top dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.x         (x),
		.y         (y),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_fire  (btn_fire),
		.rgb       (rgb)
	);

	invaders_checker u_check (
		.clk          (clk),
		.strobe       (strobe),
		.test_name    (test_name),
		.probe_x      (x),
		.probe_y      (y),
		.expected     (expected),
		.rgb          (rgb),
		.done         (done),
		.assert_fails (dut.u_sva.fail_count),
		.check_count  (check_count),
		.error_count  (error_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Finds the row box under a point, and the lowest row number wins where rows overlap
	// Returns INV_ROWS when the point is outside every row
	function automatic int row_at(input int px, input int py);
		int row;
		row = `INV_ROWS;
		if (px >= `INV_GRID_X && px <= `INV_GRID_X + `INV_ROW_LEN)
		begin
			for (int r = `INV_ROWS - 1; r >= 0; r--)
			begin
				if (py >= row_top[r] && py <= row_top[r] + `INV_ROW_H)
					row = r;
			end
		end
		return row;
	endfunction

	task automatic build_table();
		tests.push_back('{"reset invader", 0, 0, 0, 0, AT_FIXED, 200, 70, `INV_COLOR_FG});
		tests.push_back('{"reset background", 0, 0, 0, 0, AT_FIXED, 100, 200, `INV_COLOR_BG});
		tests.push_back('{"reset ship", 0, 0, 0, 0, AT_FIXED, 330, 420, `INV_COLOR_FG});
		tests.push_back('{"reset off screen", 0, 0, 0, 0, AT_FIXED, 700, 100, `INV_COLOR_NULL});
		// Ten frames left put the ship at 310..342
		tests.push_back('{"left edge", 1, 0, 0, 10, AT_FIXED, 310, 420, `INV_COLOR_FG});
		tests.push_back('{"left past ship", 0, 0, 0, 0, AT_FIXED, 343, 420, `INV_COLOR_BG});
		tests.push_back('{"right edge", 0, 1, 0, 5, AT_FIXED, 315, 420, `INV_COLOR_FG});
		tests.push_back('{"right before ship", 0, 0, 0, 0, AT_FIXED, 314, 420, `INV_COLOR_BG});
		// Ship at 475 fires at x = 489, right of the grid, so the lane is free
		tests.push_back('{"clear lane", 0, 1, 0, 160, AT_FIXED, 507, 448, `INV_COLOR_FG});
		tests.push_back('{"bullet climbing", 0, 0, 1, 20, AT_BULLET, 0, 0, `INV_COLOR_FG});
		tests.push_back('{"off screen flying", 0, 0, 0, 0, AT_FIXED, 640, 100, `INV_COLOR_NULL});
		tests.push_back('{"bullet expired", 0, 0, 0, 100, AT_FIXED, 489, 2, `INV_COLOR_BG});
		tests.push_back('{"target healthy", 0, 0, 0, -1, AT_TARGET, 0, 143, `INV_COLOR_FG});
		tests.push_back('{"fire at target", 0, 0, 1, 1, AT_BULLET, 0, 0, `INV_COLOR_FG});
		tests.push_back('{"first hit", 0, 0, 0, 70, AT_TARGET, 0, 143, `INV_COLOR_WOUNDED});
		tests.push_back('{"fire again", 0, 0, 1, 1, AT_BULLET, 0, 0, `INV_COLOR_FG});
		tests.push_back('{"second hit", 0, 0, 0, 70, AT_TARGET, 0, 143, `INV_COLOR_BG});
		tests.push_back('{"neighbour", 0, 0, 0, 0, AT_TARGET, 1, 143, `INV_COLOR_FG});
		tests.push_back('{"row above", 0, 0, 0, 0, AT_TARGET, 0, 111, `INV_COLOR_FG});
		tests.push_back('{"right of screen", 0, 0, 0, 0, AT_FIXED, 640, 0, `INV_COLOR_NULL});
		tests.push_back('{"below screen", 0, 0, 0, 0, AT_FIXED, 100, 480, `INV_COLOR_NULL});
		tests.push_back('{"far corner", 0, 0, 0, 0, AT_FIXED, 2047, 2047, `INV_COLOR_NULL});
		tests.push_back('{"last pixel", 0, 0, 0, 0, AT_FIXED, 639, 479, `INV_COLOR_BG});
	endtask

	// Each frame drives the origin with the buttons, then the pixel under the bullet
	// The bullet moves with the old ship position, then the ship moves
	task automatic run_frame(input logic l, input logic r, input logic f);
		int row;
		int col;
		int nx;
		@(negedge clk);
		x = '0;
		y = '0;
		btn_left = l;
		btn_right = r;
		btn_fire = f;
		if (!m_active)
		begin
			if (f)
			begin
				m_active = 1'b1;
				m_bx = ship_x + `INV_BULLET_DX;
				m_by = `INV_PLAYER_Y - `INV_BULLET_DY;
			end
		end
		else if (m_by == 0)
			m_active = 1'b0;
		else
			m_by = (m_by < `INV_BULLET_STEP) ? 0 : m_by - `INV_BULLET_STEP;
		nx = ship_x;
		if (l && ship_x > 1)
			nx = ship_x - 1;
		if (r && ship_x < `INV_PLAYER_XMAX)
			nx = ship_x + 1;
		ship_x = nx;

		@(negedge clk);
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_fire = 1'b0;
		x = m_active ? coord_t'(m_bx) : coord_t'(1);
		y = m_active ? coord_t'(m_by) : coord_t'(1);
		// The raster crosses the bullet here, so a live invader takes the hit
		if (m_active)
		begin
			row = row_at(m_bx, m_by);
			col = (m_bx - `INV_GRID_X) / `INV_CELL;
			if (row < `INV_ROWS && m_alive[row][col])
			begin
				if (m_healthy[row][col])
					m_healthy[row][col] = 1'b0;
				else
					m_alive[row][col] = 1'b0;
				m_active = 1'b0;
			end
		end
	endtask

	task automatic probe_pixel(input string name, input int px, input int py, input color_t c);
		@(negedge clk);
		x = coord_t'(px);
		y = coord_t'(py);
		test_name = name;
		expected = c;
		strobe = 1'b1;
		@(negedge clk);
		strobe = 1'b0;
		x = coord_t'(1);
		y = coord_t'(1);
	endtask

	task automatic watchdog(input int limit_ns);
		#(limit_ns);
		$display("Run timed out after %0d ns before the table was finished", limit_ns);
		$display("Test failed");
		$finish;
	endtask

	initial
	begin
		int px;
		int py;
		int col;
		int seek_x;
		int frames;
		int limit_ns;

		arst_n = 1'b0;
		x = coord_t'(1);
		y = coord_t'(1);
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_fire = 1'b0;
		strobe = 1'b0;
		done = 1'b0;
		expected = `INV_COLOR_NULL;
		test_name = "";
		void'($urandom(60882));
		target_col = $urandom % `INV_COLS;

		ship_x = `INV_PLAYER_X0;
		m_active = 1'b0;
		m_bx = 0;
		m_by = 0;
		for (int r = 0; r < `INV_ROWS; r++)
		begin
			for (int c = 0; c < `INV_COLS; c++)
			begin
				m_alive[r][c] = 1'b1;
				m_healthy[r][c] = 1'b1;
			end
		end
		build_table();

		// Each frame and each probe takes two cycles, and a walk is budgeted as a screen width
		frames = 0;
		foreach (tests[i])
			frames += (tests[i].frames < 0) ? `INV_SCREEN_W : tests[i].frames;
		limit_ns = (2 * frames + 2 * tests.size() + 100) * 20;
		fork
			watchdog(limit_ns);
		join_none

		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// The bullet spawns DX right of the ship and must land mid-cell
		seek_x = `INV_GRID_X + target_col * `INV_CELL + `INV_CELL / 2 - `INV_BULLET_DX;
		foreach (tests[i])
		begin
			if (tests[i].frames < 0)
			begin
				while (ship_x != seek_x)
					run_frame(ship_x > seek_x, ship_x < seek_x, 1'b0);
			end
			else
			begin
				repeat (tests[i].frames)
					run_frame(tests[i].left, tests[i].right, tests[i].fire);
			end
			px = tests[i].px;
			py = tests[i].py;
			if (tests[i].mode == AT_BULLET)
			begin
				px = m_bx;
				py = m_by;
			end
			else if (tests[i].mode == AT_TARGET)
			begin
				col = target_col + tests[i].px;
				if (col >= `INV_COLS)
					col = target_col - 1;
				px = `INV_GRID_X + col * `INV_CELL + `INV_CELL / 2;
			end
			probe_pixel(tests[i].name, px, py, tests[i].color);
		end

		repeat (2) @(negedge clk);
		done = 1'b1;
		#1;
		if (error_count == 0 && check_count == tests.size() && dut.u_sva.fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+design
design/invaders_pkg.sv
design/player_ctrl.sv
design/bullet_ctrl.sv
design/invader_grid.sv
design/pixel_painter.sv
design/invaders_top.sv
testbench/invaders_checker.sv
testbench/invaders_sva.sv
testbench/invaders_tb.sv

/* Bender.yml */
package:
  name: invaders

sources:
  - include_dirs:
      - design
    files:
      - design/invaders_pkg.sv
      - design/player_ctrl.sv
      - design/bullet_ctrl.sv
      - design/invader_grid.sv
      - design/pixel_painter.sv
      - design/invaders_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/invaders_checker.sv
      - testbench/invaders_sva.sv
      - testbench/invaders_tb.sv
